//--- files.f
logic/cache_pkg.sv
logic/cache_set_array.sv
logic/miss_controller.sv
logic/split_cache_top.sv
test/ram_model.sv
test/cache_checker.sv
test/tb_split_cache.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_split_cache \
    -f files.f -o tb_split_cache || exit 1
out=$(./obj_dir/tb_split_cache)
echo "$out"
echo "$out" | grep -qx "Simulation finished: PASS" && exit 0 || exit 1

//--- test/tb_split_cache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_split_cache;

    import cache_pkg::*;

    localparam int OFFSET_WIDTH = 3;
    localparam int INDEX_WIDTH  = 6;
    localparam int BLOCK_WIDTH  = DATA_WIDTH << OFFSET_WIDTH;
    localparam int MEM_AW       = 12;        // Tests stay in the low 4K words
    localparam int MAX_LAT      = 8;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_RANDOM   = 40;

    typedef struct packed {
        logic [7:0] test_id;
        logic       ic_en;
        ic_req_t    ic;
        logic       dc_en;
        dc_req_t    dc;
    } stim_t;

    logic                   clk;
    logic                   rst;
    logic                   ic_req_valid;
    ic_req_t                ic_req;
    logic                   ic_req_ready;
    logic                   ic_rsp_valid;
    rsp_t                   ic_rsp;
    logic                   dc_req_valid;
    dc_req_t                dc_req;
    logic                   dc_req_ready;
    logic                   dc_rsp_valid;
    rsp_t                   dc_rsp;
    logic                   ram_req_valid;
    logic                   ram_write;
    logic [ADDR_WIDTH-1:0]  ram_addr;
    logic [BLOCK_WIDTH-1:0] ram_wblock;
    logic                   ram_ack;
    logic [BLOCK_WIDTH-1:0] ram_rblock;

    int   test_num;
    int   exp_reads;
    int   exp_writes;
    int   error_count;
    logic test_end;
    logic run_done;
    int   cycle_count = 0;
    int   cycle_limit = 0;

    stim_t stim_q[$];
    // Memory transfers per test, -1 where the count is free
    int    exp_rd [7] = '{0, 0, 1, 1, 4, 2, -1};
    int    exp_wr [7] = '{0, 0, 0, 0, 2, 0, -1};

    split_cache_top #(
        .OFFSET_WIDTH (OFFSET_WIDTH),
        .INDEX_WIDTH  (INDEX_WIDTH)
    ) i_dut (.*);

    ram_model #(
        .OFFSET_WIDTH (OFFSET_WIDTH),
        .MEM_AW       (MEM_AW),
        .MAX_LAT      (MAX_LAT)
    ) i_ram (.*);

    cache_checker #(
        .OFFSET_WIDTH (OFFSET_WIDTH),
        .MEM_AW       (MEM_AW)
    ) i_check (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic stim_t make_entry(
        input int                    id,
        input logic                  ic_en,
        input logic [ADDR_WIDTH-1:0] ic_addr,
        input logic                  dc_en,
        input logic                  write,
        input logic [BE_WIDTH-1:0]   byte_en,
        input logic [ADDR_WIDTH-1:0] dc_addr,
        input logic [DATA_WIDTH-1:0] wdata
    );
        stim_t s;
        s.test_id = 8'(id);
        s.ic_en   = ic_en;
        s.ic.addr = ic_addr;
        s.dc_en   = dc_en;
        s.dc      = '{addr: dc_addr, write: write, byte_en: byte_en, wdata: wdata};
        return s;
    endfunction

    ////////////////////////////////////////
    // Stimulus table
    ////////////////////////////////////////
    function automatic void build_table();
        logic [ADDR_WIDTH-1:0] ic_addr;
        logic [ADDR_WIDTH-1:0] dc_addr;
        repeat (4) stim_q.push_back(make_entry(1, 0, '0, 0, 0, '0, '0, '0));
        // Fetch miss, then the same fetch hits
        stim_q.push_back(make_entry(2, 1, 30'h844, 0, 0, '0, '0, '0));
        stim_q.push_back(make_entry(2, 1, 30'h844, 0, 0, '0, '0, '0));
        stim_q.push_back(make_entry(3, 0, '0, 1, 1, 4'b0101, 30'h013, 32'hdeadbeef));
        stim_q.push_back(make_entry(3, 0, '0, 1, 0, 4'hf, 30'h013, '0));
        // Three tags in set 5, then the first one again
        stim_q.push_back(make_entry(4, 0, '0, 1, 1, 4'hf, 30'h028, 32'h11223344));
        stim_q.push_back(make_entry(4, 0, '0, 1, 1, 4'b0011, 30'h228, 32'h55667788));
        stim_q.push_back(make_entry(4, 0, '0, 1, 1, 4'b1100, 30'h428, 32'h99aabbcc));
        stim_q.push_back(make_entry(4, 0, '0, 1, 0, 4'hf, 30'h028, '0));
        stim_q.push_back(make_entry(5, 1, 30'h900, 1, 0, 4'hf, 30'h100, '0));
        // Four tags over four sets on each side, so lines hit, miss and get evicted
        for (int n = 0; n < NUM_RANDOM; n++) begin
            ic_addr = 30'h800 + ADDR_WIDTH'($urandom_range(0, 3) * 'h200 +
                                            $urandom_range(0, 'h1f));   // Code region
            dc_addr = ADDR_WIDTH'($urandom_range(0, 3) * 'h200 +
                                  $urandom_range(0, 'h1f));             // Data region
            stim_q.push_back(make_entry(6, 1'($urandom_range(0, 1)), ic_addr,
                                        1'($urandom_range(0, 1)), 1'($urandom_range(0, 1)),
                                        4'($urandom_range(1, 15)), dc_addr, $urandom));
        end
    endfunction

    // Drive one entry and hold it until the handshake
    task automatic apply_entry(input stim_t s);
        @(posedge clk);
        test_num     <= s.test_id;
        ic_req_valid <= s.ic_en;
        ic_req       <= s.ic;
        dc_req_valid <= s.dc_en;
        dc_req       <= s.dc;
        if (s.ic_en || s.dc_en) begin
            do @(negedge clk);
            while (!((!s.ic_en || ic_req_ready) && (!s.dc_en || dc_req_ready)));
        end
    endtask

    task automatic end_test(input int id);
        @(posedge clk);                     // Last entry accepted here
        ic_req_valid <= 1'b0;
        dc_req_valid <= 1'b0;
        @(posedge clk);
        exp_reads    <= exp_rd[id];
        exp_writes   <= exp_wr[id];
        test_end     <= 1'b1;
        @(posedge clk);
        test_end     <= 1'b0;
    endtask

    initial begin
        logic [DATA_WIDTH-1:0] word;
        rst          = 1'b1;
        ic_req_valid = 1'b0;
        ic_req       = '0;
        dc_req_valid = 1'b0;
        dc_req       = '0;
        test_num     = 0;
        exp_reads    = -1;
        exp_writes   = -1;
        test_end     = 1'b0;
        run_done     = 1'b0;
        void'($urandom(32'he311a54a));
        for (int a = 0; a < (1 << MEM_AW); a++) begin
            word = $urandom;
            i_ram.mem[a]      = word;
            i_check.shadow[a] = word;
        end
        build_table();
        cycle_limit = stim_q.size() * 3 * MAX_LAT * 2 + RESET_CYCLES;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < stim_q.size(); i++) begin
            apply_entry(stim_q[i]);
            if (i == stim_q.size() - 1 || stim_q[i+1].test_id != stim_q[i].test_id) begin
                end_test(int'(stim_q[i].test_id));
            end
        end
        @(posedge clk);
        run_done <= 1'b1;
        @(posedge clk);
        run_done <= 1'b0;
        @(negedge clk);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // Watchdog sized from the table length
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Run timed out after %0d cycles before the table was done", cycle_count);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- test/cache_checker.sv
`timescale 1ns/1ps
`default_nettype none

module cache_checker #(
    parameter int OFFSET_WIDTH = 3,
    parameter int MEM_AW       = 12
) (
    input  wire logic                                          clk,
    input  wire logic                                          rst,
    input  wire logic                                          ic_req_valid,
    input  wire cache_pkg::ic_req_t                            ic_req,
    input  wire logic                                          ic_req_ready,
    input  wire logic                                          ic_rsp_valid,
    input  wire cache_pkg::rsp_t                               ic_rsp,
    input  wire logic                                          dc_req_valid,
    input  wire cache_pkg::dc_req_t                            dc_req,
    input  wire logic                                          dc_req_ready,
    input  wire logic                                          dc_rsp_valid,
    input  wire cache_pkg::rsp_t                               dc_rsp,
    input  wire logic                                          ram_req_valid,
    input  wire logic                                          ram_write,
    input  wire logic [cache_pkg::ADDR_WIDTH-1:0]              ram_addr,
    input  wire logic [(cache_pkg::DATA_WIDTH<<OFFSET_WIDTH)-1:0] ram_wblock,
    input  wire logic                                          ram_ack,
    input  var int                                             test_num,
    input  var int                                             exp_reads,
    input  var int                                             exp_writes,
    input  wire logic                                          test_end,
    input  wire logic                                          run_done,
    output int                                                 error_count
);

    import cache_pkg::*;

    localparam int WORDS = 1 << OFFSET_WIDTH;

    logic [DATA_WIDTH-1:0] shadow [1<<MEM_AW];  // Mirror of memory contents
    logic                  ic_pend;
    logic                  dc_pend;
    logic [DATA_WIDTH-1:0] ic_exp;
    logic [DATA_WIDTH-1:0] dc_exp;
    int                    test_checks;
    int                    test_errs;
    int                    total_checks;
    int                    tests_done;
    int                    reads;
    int                    writes;

    function automatic logic [DATA_WIDTH-1:0] merge_bytes(
        input logic [DATA_WIDTH-1:0] old_word,
        input logic [DATA_WIDTH-1:0] new_word,
        input logic [BE_WIDTH-1:0]   byte_en
    );
        logic [DATA_WIDTH-1:0] merged;
        merged = old_word;
        for (int b = 0; b < BE_WIDTH; b++) begin
            if (byte_en[b]) begin
                merged[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return merged;
    endfunction

    task automatic compare_word(input string name, input logic [DATA_WIDTH-1:0] got,
                                input logic [DATA_WIDTH-1:0] exp);
        test_checks++;
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h expected %h in test %0d", name, got, exp,
                     test_num);
            test_errs++;
            error_count++;
        end
    endtask

    task automatic report_error(input string msg);
        $display("Test %0d: %s", test_num, msg);
        test_errs++;
        error_count++;
    endtask

    always @(posedge clk) begin
        if (rst) begin
            ic_pend      = 1'b0;
            dc_pend      = 1'b0;
            test_checks  = 0;
            test_errs    = 0;
            total_checks = 0;
            tests_done   = 0;
            reads        = 0;
            writes       = 0;
            error_count  = 0;
        end else begin
            ////////////////////////////////////////
            // Responses, one cycle after acceptance
            ////////////////////////////////////////
            if (ic_pend) begin
                if (ic_rsp_valid) compare_word("ic_rsp.data", ic_rsp.data, ic_exp);
                else report_error("instruction response missing one cycle after acceptance");
            end else if (ic_rsp_valid) begin
                report_error("instruction response without an accepted fetch");
            end
            if (dc_pend) begin
                if (dc_rsp_valid) compare_word("dc_rsp.data", dc_rsp.data, dc_exp);
                else report_error("data response missing one cycle after acceptance");
            end else if (dc_rsp_valid) begin
                report_error("data response without an accepted read");
            end

            // Quiet ports while nothing is requested after reset
            if (test_num == 1 && (ic_req_ready || dc_req_ready || ic_rsp_valid ||
                                  dc_rsp_valid || ram_req_valid)) begin
                report_error("ready, response or memory request active before any request");
            end

            if (ram_req_valid && ram_ack) begin
                if (ram_write) begin
                    writes++;
                    for (int w = 0; w < WORDS; w++) begin
                        compare_word("ram_wblock", ram_wblock[w*DATA_WIDTH +: DATA_WIDTH],
                                     shadow[ram_addr[MEM_AW-1:0] + w]);
                    end
                end else begin
                    reads++;
                end
            end

            // Expected words captured before this cycle's store lands
            ic_pend = ic_req_valid && ic_req_ready;
            ic_exp  = shadow[ic_req.addr[MEM_AW-1:0]];
            dc_pend = dc_req_valid && dc_req_ready && !dc_req.write;
            dc_exp  = shadow[dc_req.addr[MEM_AW-1:0]];
            if (dc_req_valid && dc_req_ready && dc_req.write) begin
                shadow[dc_req.addr[MEM_AW-1:0]] = merge_bytes(
                    shadow[dc_req.addr[MEM_AW-1:0]], dc_req.wdata, dc_req.byte_en);
            end

            if (test_end) begin
                if (exp_reads >= 0 && reads != exp_reads) begin
                    report_error($sformatf("%0d memory reads, expected %0d", reads, exp_reads));
                end
                if (exp_writes >= 0 && writes != exp_writes) begin
                    report_error($sformatf("%0d memory writes, expected %0d", writes,
                                           exp_writes));
                end
                $display("Test %0d finished: %0d checks, %0d errors", test_num, test_checks,
                         test_errs);
                tests_done++;
                total_checks += test_checks;
                test_checks  = 0;
                test_errs    = 0;
                reads        = 0;
                writes       = 0;
            end
            if (run_done) begin
                $display("Totals: %0d tests, %0d checks, %0d errors", tests_done,
                         total_checks, error_count);
            end
        end
    end

endmodule

`default_nettype wire

//--- test/ram_model.sv
`timescale 1ns/1ps
`default_nettype none

module ram_model #(
    parameter int OFFSET_WIDTH = 3,
    parameter int MEM_AW       = 12,
    parameter int MAX_LAT      = 8
) (
    input  wire logic                                          clk,
    input  wire logic                                          rst,
    input  wire logic                                          ram_req_valid,
    input  wire logic                                          ram_write,
    input  wire logic [cache_pkg::ADDR_WIDTH-1:0]              ram_addr,
    input  wire logic [(cache_pkg::DATA_WIDTH<<OFFSET_WIDTH)-1:0] ram_wblock,
    output logic                                               ram_ack,
    output logic [(cache_pkg::DATA_WIDTH<<OFFSET_WIDTH)-1:0]   ram_rblock
);

    import cache_pkg::*;

    localparam int WORDS = 1 << OFFSET_WIDTH;

    logic [DATA_WIDTH-1:0] mem [1<<MEM_AW];    // Preloaded by the testbench
    logic                  busy;
    int unsigned           wait_cnt;
    logic [MEM_AW-1:0]     base;

    assign base = ram_addr[MEM_AW-1:0];

    always @(posedge clk) begin
        if (rst) begin
            ram_ack  <= 1'b0;
            busy     <= 1'b0;
            wait_cnt <= 0;
        end else if (ram_ack) begin
            ram_ack <= 1'b0;                    // One pulse per transfer
        end else if (busy) begin
            if (wait_cnt == 0) begin
                ram_ack <= 1'b1;
                busy    <= 1'b0;
                for (int w = 0; w < WORDS; w++) begin
                    if (ram_write) begin
                        mem[base + w] = ram_wblock[w*DATA_WIDTH +: DATA_WIDTH];
                    end else begin
                        ram_rblock[w*DATA_WIDTH +: DATA_WIDTH] <= mem[base + w];
                    end
                end
            end else begin
                wait_cnt <= wait_cnt - 1;
            end
        end else if (ram_req_valid) begin
            busy     <= 1'b1;
            wait_cnt <= $urandom_range(0, MAX_LAT - 1);  // Random latency
        end
    end

endmodule

`default_nettype wire

//--- logic/split_cache_top.sv
`timescale 1ns/1ps
`default_nettype none

module split_cache_top #(
    parameter int OFFSET_WIDTH = 3,
    parameter int INDEX_WIDTH  = 6
) (
    input  wire logic                                          clk,
    input  wire logic                                          rst,
    // Instruction side
    input  wire logic                                          ic_req_valid,
    input  wire cache_pkg::ic_req_t                            ic_req,
    output logic                                               ic_req_ready,
    output logic                                               ic_rsp_valid,
    output cache_pkg::rsp_t                                    ic_rsp,
    // Data side
    input  wire logic                                          dc_req_valid,
    input  wire cache_pkg::dc_req_t                            dc_req,
    output logic                                               dc_req_ready,
    output logic                                               dc_rsp_valid,
    output cache_pkg::rsp_t                                    dc_rsp,
    // Memory
    output logic                                               ram_req_valid,
    output logic                                               ram_write,
    output logic [cache_pkg::ADDR_WIDTH-1:0]                   ram_addr,
    output logic [(cache_pkg::DATA_WIDTH<<OFFSET_WIDTH)-1:0]   ram_wblock,
    input  wire logic                                          ram_ack,
    input  wire logic [(cache_pkg::DATA_WIDTH<<OFFSET_WIDTH)-1:0] ram_rblock
);

    import cache_pkg::*;

    localparam int BLOCK_WIDTH = DATA_WIDTH << OFFSET_WIDTH;

    lookup_t                ic_result;
    lookup_t                dc_result;
    array_cmd_t             ic_cmd;
    array_cmd_t             dc_cmd;
    logic [BLOCK_WIDTH-1:0] dc_victim_block;

    ////////////////////////////////////////
    // Arrays
    ////////////////////////////////////////
    cache_set_array #(
        .OFFSET_WIDTH (OFFSET_WIDTH),
        .INDEX_WIDTH  (INDEX_WIDTH)
    ) i_icache (
        .clk          (clk),
        .rst          (rst),
        .addr         (ic_req.addr),
        .cmd          (ic_cmd),
        .fill_block   (ram_rblock),
        .result       (ic_result),
        .victim_block ()                // Instruction lines are never dirty
    );

    cache_set_array #(
        .OFFSET_WIDTH (OFFSET_WIDTH),
        .INDEX_WIDTH  (INDEX_WIDTH)
    ) i_dcache (
        .clk          (clk),
        .rst          (rst),
        .addr         (dc_req.addr),
        .cmd          (dc_cmd),
        .fill_block   (ram_rblock),
        .result       (dc_result),
        .victim_block (dc_victim_block)
    );

    // Miss handling and memory port
    miss_controller #(
        .OFFSET_WIDTH (OFFSET_WIDTH),
        .INDEX_WIDTH  (INDEX_WIDTH)
    ) i_ctrl (
        .clk             (clk),
        .rst             (rst),
        .ic_req_valid    (ic_req_valid),
        .ic_req          (ic_req),
        .ic_req_ready    (ic_req_ready),
        .ic_rsp_valid    (ic_rsp_valid),
        .ic_rsp          (ic_rsp),
        .dc_req_valid    (dc_req_valid),
        .dc_req          (dc_req),
        .dc_req_ready    (dc_req_ready),
        .dc_rsp_valid    (dc_rsp_valid),
        .dc_rsp          (dc_rsp),
        .ic_result       (ic_result),
        .dc_result       (dc_result),
        .dc_victim_block (dc_victim_block),
        .ic_cmd          (ic_cmd),
        .dc_cmd          (dc_cmd),
        .ram_req_valid   (ram_req_valid),
        .ram_write       (ram_write),
        .ram_addr        (ram_addr),
        .ram_wblock      (ram_wblock),
        .ram_ack         (ram_ack)
    );

endmodule

`default_nettype wire

//--- logic/miss_controller.sv
`timescale 1ns/1ps
`default_nettype none

module miss_controller #(
    parameter int OFFSET_WIDTH = 3,
    parameter int INDEX_WIDTH  = 6
) (
    input  wire logic                                          clk,
    input  wire logic                                          rst,
    // Instruction side
    input  wire logic                                          ic_req_valid,
    input  wire cache_pkg::ic_req_t                            ic_req,
    output logic                                               ic_req_ready,
    output logic                                               ic_rsp_valid,
    output cache_pkg::rsp_t                                    ic_rsp,
    // Data side
    input  wire logic                                          dc_req_valid,
    input  wire cache_pkg::dc_req_t                            dc_req,
    output logic                                               dc_req_ready,
    output logic                                               dc_rsp_valid,
    output cache_pkg::rsp_t                                    dc_rsp,
    // Arrays
    input  wire cache_pkg::lookup_t                            ic_result,
    input  wire cache_pkg::lookup_t                            dc_result,
    input  wire logic [(cache_pkg::DATA_WIDTH<<OFFSET_WIDTH)-1:0] dc_victim_block,
    output cache_pkg::array_cmd_t                              ic_cmd,
    output cache_pkg::array_cmd_t                              dc_cmd,
    // Memory
    output logic                                               ram_req_valid,
    output logic                                               ram_write,
    output logic [cache_pkg::ADDR_WIDTH-1:0]                   ram_addr,
    output logic [(cache_pkg::DATA_WIDTH<<OFFSET_WIDTH)-1:0]   ram_wblock,
    input  wire logic                                          ram_ack
);

    import cache_pkg::*;

    localparam int TAG_WIDTH = ADDR_WIDTH - OFFSET_WIDTH - INDEX_WIDTH;

    miss_state_e state;
    miss_state_e state_next;

    logic ic_miss;
    logic dc_miss;
    logic dc_wb_needed;
    logic all_hit;
    logic ic_accept;
    logic dc_accept;

    logic [INDEX_WIDTH-1:0] dc_index;

    ////////////////////////////////////////
    // Lookup combine
    ////////////////////////////////////////
    assign ic_miss      = ic_req_valid && !ic_result.hit;
    assign dc_miss      = dc_req_valid && !dc_result.hit;
    assign dc_wb_needed = dc_result.victim_valid && dc_result.victim_dirty;
    assign all_hit      = !ic_miss && !dc_miss;

    // Both sides released together, only when something is asking
    assign ic_req_ready = (state == ST_IDLE) && all_hit && (ic_req_valid || dc_req_valid);
    assign dc_req_ready = ic_req_ready;

    assign ic_accept = ic_req_valid && ic_req_ready;
    assign dc_accept = dc_req_valid && dc_req_ready;

    ////////////////////////////////////////
    // State machine
    ////////////////////////////////////////
    always_comb begin
        state_next = state;
        unique case (state)
            ST_IDLE: begin
                if (dc_miss && dc_wb_needed) begin
                    state_next = ST_WRITEBACK;
                end else if (dc_miss) begin
                    state_next = ST_DC_FILL;
                end else if (ic_miss) begin
                    state_next = ST_IC_FILL;
                end
            end
            ST_WRITEBACK: if (ram_ack) state_next = ST_DC_FILL;
            ST_DC_FILL: begin
                if (ram_ack) begin
                    state_next = ic_miss ? ST_IC_FILL : ST_RESPOND;
                end
            end
            ST_IC_FILL: if (ram_ack) state_next = ST_RESPOND;
            ST_RESPOND: state_next = ST_IDLE;     // Arrays settle after the fill
            default:    state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    ////////////////////////////////////////
    // Array commands
    ////////////////////////////////////////
    always_comb begin
        ic_cmd.op      = OP_LOOKUP;
        ic_cmd.way     = ic_result.victim_way;
        ic_cmd.byte_en = '0;
        ic_cmd.wdata   = '0;              // Never written from the CPU
        if (state == ST_IC_FILL && ram_ack) begin
            ic_cmd.op = OP_FILL;
        end
    end

    always_comb begin
        dc_cmd.op      = OP_LOOKUP;
        dc_cmd.way     = dc_result.hit_way;
        dc_cmd.byte_en = dc_req.byte_en;
        dc_cmd.wdata   = dc_req.wdata;
        if (dc_accept && dc_req.write) begin
            dc_cmd.op = OP_WRITE;         // Store lands in the accept cycle
        end else if (state == ST_DC_FILL && ram_ack) begin
            dc_cmd.op  = OP_FILL;
            dc_cmd.way = dc_result.victim_way;
        end
    end

    ////////////////////////////////////////
    // Responses
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            ic_rsp_valid <= 1'b0;
            dc_rsp_valid <= 1'b0;
        end else begin
            ic_rsp_valid <= ic_accept;
            dc_rsp_valid <= dc_accept && !dc_req.write;   // Stores are silent
        end
    end

    always_ff @(posedge clk) begin
        ic_rsp.data <= ic_result.word;
        dc_rsp.data <= dc_result.word;
    end

    ////////////////////////////////////////
    // Memory port
    ////////////////////////////////////////
    assign dc_index = dc_req.addr[OFFSET_WIDTH +: INDEX_WIDTH];

    assign ram_req_valid = (state == ST_WRITEBACK) || (state == ST_DC_FILL) ||
                           (state == ST_IC_FILL);
    assign ram_write     = (state == ST_WRITEBACK);
    assign ram_wblock    = dc_victim_block;

    always_comb begin
        case (state)
            ST_WRITEBACK: ram_addr = {dc_result.victim_tag[TAG_WIDTH-1:0], dc_index,
                                      {OFFSET_WIDTH{1'b0}}};
            ST_IC_FILL:   ram_addr = {ic_req.addr[ADDR_WIDTH-1:OFFSET_WIDTH],
                                      {OFFSET_WIDTH{1'b0}}};
            default:      ram_addr = {dc_req.addr[ADDR_WIDTH-1:OFFSET_WIDTH],
                                      {OFFSET_WIDTH{1'b0}}};
        endcase
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    // Depends on the CPU holding its request and the arrays staying still
    a_ram_req_stable: assert property (
        @(posedge clk) disable iff (rst)
        (ram_req_valid && !ram_ack) |=>
            (ram_req_valid && $stable(ram_addr) && $stable(ram_write) &&
             (!ram_write || $stable(ram_wblock)))
    );

    // A transfer ends in another fill step or the settle cycle, never in a handshake
    a_no_ready_after_ack: assert property (
        @(posedge clk) disable iff (rst)
        ram_ack |=> !(ic_req_ready || dc_req_ready)
    );

endmodule

`default_nettype wire

//--- logic/cache_set_array.sv
`timescale 1ns/1ps
`default_nettype none

module cache_set_array #(
    parameter int OFFSET_WIDTH = 3,
    parameter int INDEX_WIDTH  = 6
) (
    input  wire logic                                          clk,
    input  wire logic                                          rst,
    input  wire logic [cache_pkg::ADDR_WIDTH-1:0]              addr,
    input  wire cache_pkg::array_cmd_t                         cmd,
    input  wire logic [(cache_pkg::DATA_WIDTH<<OFFSET_WIDTH)-1:0] fill_block,
    output cache_pkg::lookup_t                                 result,
    output logic [(cache_pkg::DATA_WIDTH<<OFFSET_WIDTH)-1:0]   victim_block
);

    import cache_pkg::*;

    localparam int TAG_WIDTH   = ADDR_WIDTH - OFFSET_WIDTH - INDEX_WIDTH;
    localparam int DEPTH       = 1 << INDEX_WIDTH;
    localparam int BLOCK_WIDTH = DATA_WIDTH << OFFSET_WIDTH;

    ////////////////////////////////////////
    // Storage
    ////////////////////////////////////////
    logic [TAG_WIDTH-1:0]   tag_mem  [2][DEPTH];
    logic [BLOCK_WIDTH-1:0] data_mem [2][DEPTH];
    logic [1:0][DEPTH-1:0]  valid;
    logic [1:0][DEPTH-1:0]  dirty;
    logic [DEPTH-1:0]       lru;        // Way to evict next

    logic [TAG_WIDTH-1:0]    tag;
    logic [INDEX_WIDTH-1:0]  index;
    logic [OFFSET_WIDTH-1:0] offset;
    logic [1:0]              way_hit;
    logic                    vway;

    assign tag    = addr[ADDR_WIDTH-1 -: TAG_WIDTH];
    assign index  = addr[OFFSET_WIDTH +: INDEX_WIDTH];
    assign offset = addr[OFFSET_WIDTH-1:0];

    ////////////////////////////////////////
    // Lookup
    ////////////////////////////////////////
    always_comb begin
        for (int w = 0; w < 2; w++) begin
            way_hit[w] = valid[w][index] && (tag_mem[w][index] == tag);
        end
    end

    assign vway = lru[index];

    always_comb begin
        result.hit          = |way_hit;
        result.hit_way      = way_hit[1];     // Way 0 unless way 1 matched
        result.victim_way   = vway;
        result.victim_valid = valid[vway][index];
        result.victim_dirty = dirty[vway][index];
        result.victim_tag   = {{(ADDR_WIDTH-TAG_WIDTH){1'b0}}, tag_mem[vway][index]};
        result.word         = data_mem[way_hit[1]][index][offset*DATA_WIDTH +: DATA_WIDTH];
    end

    assign victim_block = data_mem[vway][index];

    ////////////////////////////////////////
    // Payload update
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        case (cmd.op)
            OP_WRITE: begin
                // Byte merge into the addressed word
                for (int b = 0; b < BE_WIDTH; b++) begin
                    if (cmd.byte_en[b]) begin
                        data_mem[cmd.way][index][offset*DATA_WIDTH + b*8 +: 8] <=
                            cmd.wdata[b*8 +: 8];
                    end
                end
            end
            OP_FILL: begin
                data_mem[cmd.way][index] <= fill_block;
                tag_mem[cmd.way][index]  <= tag;
            end
            default: begin
            end
        endcase
    end

    // Line state and replacement
    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
            dirty <= '0;
            lru   <= '0;
        end else begin
            case (cmd.op)
                OP_LOOKUP: begin
                    if (result.hit) begin
                        lru[index] <= ~result.hit_way;  // Touch on hit
                    end
                end
                OP_WRITE: begin
                    dirty[cmd.way][index] <= 1'b1;
                    lru[index]            <= ~cmd.way;
                end
                OP_FILL: begin
                    valid[cmd.way][index] <= 1'b1;
                    dirty[cmd.way][index] <= 1'b0;      // Fresh from memory
                    lru[index]            <= ~cmd.way;
                end
                default: begin
                end
            endcase
        end
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    // A fill only ever targets the victim, so one tag lives in one way
    a_single_way_hit: assert property (
        @(posedge clk) disable iff (rst)
        !(way_hit[0] && way_hit[1])
    );

    // Controller only writes a line it has just seen hit
    a_write_needs_hit: assert property (
        @(posedge clk) disable iff (rst)
        (cmd.op == OP_WRITE) |-> (result.hit && (result.hit_way == cmd.way))
    );

endmodule

`default_nettype wire

//--- logic/cache_pkg.sv
`default_nettype none

package cache_pkg;

    ////////////////////////////////////////
    // Fixed widths
    ////////////////////////////////////////
    localparam int DATA_WIDTH = 32;     // Word size in bits
    localparam int ADDR_WIDTH = 30;     // Word address
    localparam int BE_WIDTH   = DATA_WIDTH / 8;

    // Instruction fetch
    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;
    } ic_req_t;

    // Data access, 67 bits
    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;
        logic                  write;
        logic [BE_WIDTH-1:0]   byte_en;
        logic [DATA_WIDTH-1:0] wdata;
    } dc_req_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
    } rsp_t;

    ////////////////////////////////////////
    // Array interface
    ////////////////////////////////////////
    typedef enum logic [1:0] {
        OP_LOOKUP,
        OP_WRITE,
        OP_FILL
    } array_op_e;

    typedef struct packed {
        array_op_e             op;
        logic                  way;
        logic [BE_WIDTH-1:0]   byte_en;
        logic [DATA_WIDTH-1:0] wdata;
    } array_cmd_t;

    typedef struct packed {
        logic                  hit;
        logic                  hit_way;
        logic                  victim_way;
        logic                  victim_valid;
        logic                  victim_dirty;
        logic [ADDR_WIDTH-1:0] victim_tag;  // Zero-extended
        logic [DATA_WIDTH-1:0] word;
    } lookup_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_WRITEBACK,
        ST_DC_FILL,
        ST_IC_FILL,
        ST_RESPOND
    } miss_state_e;

endpackage

`default_nettype wire
